// ==== design/beeb_settings.svh ====
`ifndef BEEB_SETTINGS_SVH
`define BEEB_SETTINGS_SVH

// ==================================================
// memory bus geometry
// ==================================================
// core address bus, bit 18 splits ram from rom
`define BEEB_ADDR_W 19
// byte offset inside one 16 KB sideways bank
`define BEEB_BANK_BITS 14
// physical rom banks, 8 K words each
`define BEEB_ROM_BANKS 14
// rom word address, bank number plus word offset
`define BEEB_ROM_AW 17
// byte ram behind the upper half of the bus
`define BEEB_RAM_BYTES 212992

// ==================================================
// mouse-as-joystick limits
// ==================================================
`define BEEB_DELTA_CLAMP 10
`define BEEB_POS_MIN (-128)
`define BEEB_POS_MAX 127

// sd activity hold in clk_sys cycles
`define BEEB_SD_ACT_HOLD 4096

`endif

// ==== design/beeb_pkg.sv ====
`include "beeb_settings.svh"

package beeb_pkg;

	// ==================================================
	// memory side
	// ==================================================

	// bus request from the core
	typedef struct packed {
		// write strobe, active low
		logic                    we_n;
		logic [`BEEB_ADDR_W-1:0] addr;
		logic [7:0]              wdata;
	} mem_bus_t;

	// one loader word, wr is a single-cycle pulse
	typedef struct packed {
		logic                    wr;
		logic [`BEEB_ROM_AW-1:0] addr;
		// high byte is the even byte of the image
		logic [15:0]             data;
	} rom_load_t;

	// physical rom bank number
	typedef logic [3:0] rom_bank_t;

	// ==================================================
	// input devices
	// ==================================================

	// mouse packet, new packet on any change of toggle
	typedef struct packed {
		logic       toggle;
		logic [1:0] buttons;
		logic [7:0] dx;
		// dy positive means upward
		logic [7:0] dy;
		logic       dx_sign;
		logic       dy_sign;
	} mouse_pkt_t;

	// game joystick as delivered by the host
	typedef struct packed {
		logic [15:0] any_dir_or_button;
		logic [7:0]  x;
		logic [7:0]  y;
		logic        fire;
	} joy_in_t;

	// analog joystick as seen by the core
	typedef struct packed {
		logic [7:0] x;
		logic [7:0] y;
		logic       fire;
	} joy_axes_t;

endpackage

// ==== design/rom_bank_map.sv ====
module rom_bank_map (
	input  logic                master,
	input  logic [3:0]          bus_bank,
	output beeb_pkg::rom_bank_t bank,
	output logic                hit
);

	// ==================================================
	// sideways bank decode
	// ==================================================
	// model b owns physical banks 0..3
	// master owns physical banks 4..13
	// anything not listed reads as empty

	always_comb begin
		bank = 4'd0;
		hit  = 1'b1;
		case ({master, bus_bank})
			// model b: os
			5'b0_0100: bank = 4'd0;
			// model b: filing system
			5'b0_1000: bank = 4'd1;
			// model b: ram utility
			5'b0_1110: bank = 4'd2;
			// model b: basic
			5'b0_1111: bank = 4'd3;
			// master: adfs
			5'b1_0010: bank = 4'd4;
			// master: mmfs
			5'b1_0011: bank = 4'd5;
			// master: mos
			5'b1_0100: bank = 4'd6;
			// master: dfs
			5'b1_1001: bank = 4'd7;
			// master: spreadsheet
			5'b1_1010: bank = 4'd8;
			// master: editor
			5'b1_1011: bank = 4'd9;
			// master: basic
			5'b1_1100: bank = 4'd10;
			// master: second adfs
			5'b1_1101: bank = 4'd11;
			// master: word processor
			5'b1_1110: bank = 4'd12;
			// master: terminal
			5'b1_1111: bank = 4'd13;
			default: begin
				// empty slot
				bank = 4'd0;
				hit  = 1'b0;
			end
		endcase
	end

endmodule

// ==== design/rom_store.sv ====
`include "beeb_settings.svh"

module rom_store (
	input  logic                    clk_sys,
	input  logic                    machine_reset,
	input  beeb_pkg::rom_load_t     load,
	input  logic [`BEEB_ADDR_W-1:0] bus_addr,
	input  logic                    master,
	output logic [7:0]              rdata
);

	localparam int ROM_WORDS = `BEEB_ROM_BANKS << (`BEEB_BANK_BITS - 1);

	logic [15:0]             rom [ROM_WORDS];
	beeb_pkg::rom_bank_t     phys_bank;
	logic                    bank_hit;
	logic [`BEEB_ROM_AW-1:0] rd_addr;
	logic [15:0]             rd_word;
	logic                    hit_q;
	logic                    odd_q;

	// bus bank number is address bits 17 to 14
	rom_bank_map rom_bank_map_inst (
		.master   (master),
		.bus_bank (bus_addr[`BEEB_BANK_BITS+3:`BEEB_BANK_BITS]),
		.bank     (phys_bank),
		.hit      (bank_hit)
	);

	// physical bank joined with the word offset
	assign rd_addr = {phys_bank, bus_addr[`BEEB_BANK_BITS-1:1]};

	// loader port, only while the machine is held
	always_ff @(posedge clk_sys) begin
		if (load.wr && machine_reset) begin
			rom[load.addr] <= load.data;
		end
	end

	// read port, byte select and hit travel with the word
	always_ff @(posedge clk_sys) begin
		rd_word <= rom[rd_addr];
		hit_q   <= bank_hit;
		odd_q   <= bus_addr[0];
	end

	// even byte sits in the high half
	assign rdata = !hit_q ? 8'h00 : (odd_q ? rd_word[7:0] : rd_word[15:8]);

	// loader must never run against a live core
	assert property (@(posedge clk_sys) load.wr |-> machine_reset);

endmodule

// ==== design/ram_store.sv ====
`include "beeb_settings.svh"

module ram_store (
	input  logic               clk_sys,
	input  beeb_pkg::mem_bus_t req,
	output logic [7:0]         rdata
);

	logic [7:0] ram [`BEEB_RAM_BYTES];
	logic       we_n_q;
	logic       wr_en;

	// ==================================================
	// write strobe edge detect
	// ==================================================
	// one write per low pulse of we_n
	// only the upper half of the bus is ram

	always_ff @(posedge clk_sys) begin
		we_n_q <= req.we_n;
	end

	assign wr_en = req.addr[`BEEB_ADDR_W-1] && we_n_q && !req.we_n;

	// address and data taken at the falling-edge cycle
	always_ff @(posedge clk_sys) begin
		if (wr_en) begin
			ram[req.addr[`BEEB_ADDR_W-2:0]] <= req.wdata;
		end
	end

	// registered read
	always_ff @(posedge clk_sys) begin
		rdata <= ram[req.addr[`BEEB_ADDR_W-2:0]];
	end

	// a ram write always lands inside the array
	assert property (@(posedge clk_sys)
		wr_en |-> req.addr[`BEEB_ADDR_W-2:0] < `BEEB_RAM_BYTES);

endmodule

// ==== design/mem_subsystem.sv ====
`include "beeb_settings.svh"

module mem_subsystem (
	input  logic                clk_sys,
	input  logic                rst,
	input  logic                machine_reset,
	input  logic                model_master,
	input  beeb_pkg::rom_load_t rom_load,
	input  beeb_pkg::mem_bus_t  mem_req,
	output logic [7:0]          mem_rdata
);

	logic       master;
	logic       ram_sel_q;
	logic [7:0] rom_rdata;
	logic [7:0] ram_rdata;

	// ==================================================
	// model latch
	// ==================================================
	// follows model_master only while the machine is in reset
	// rst falls back to model b

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			master <= 1'b0;
		end else if (machine_reset) begin
			master <= model_master;
		end
	end

	// sideways rom, read through the model map
	rom_store rom_store_inst (
		.clk_sys       (clk_sys),
		.machine_reset (machine_reset),
		.load          (rom_load),
		.bus_addr      (mem_req.addr),
		.master        (master),
		.rdata         (rom_rdata)
	);

	// main and shadow ram
	ram_store ram_store_inst (
		.clk_sys (clk_sys),
		.req     (mem_req),
		.rdata   (ram_rdata)
	);

	// ==================================================
	// read data select
	// ==================================================
	// bit 18 staged alongside both read ports

	always_ff @(posedge clk_sys) begin
		ram_sel_q <= mem_req.addr[`BEEB_ADDR_W-1];
	end

	assign mem_rdata = ram_sel_q ? ram_rdata : rom_rdata;

endmodule

// ==== design/mouse_joystick.sv ====
`include "beeb_settings.svh"

module mouse_joystick (
	input  logic                 clk_sys,
	input  logic                 rst,
	input  logic                 machine_reset,
	input  logic                 mouse_off,
	input  beeb_pkg::mouse_pkt_t mouse,
	input  beeb_pkg::joy_in_t    joy,
	output beeb_pkg::joy_axes_t  axes
);

	logic              toggle_q;
	logic              mouse_mode;
	logic              pkt_new;
	logic              clear_req;
	logic signed [8:0] pos_x;
	logic signed [8:0] pos_y;
	logic signed [8:0] dx_ext;
	logic signed [8:0] dy_ext;
	logic signed [8:0] sum_x;
	logic signed [8:0] sum_y;

	// limit one packet's movement
	function automatic logic signed [8:0] clamp_delta(input logic signed [8:0] d);
		if (d > `BEEB_DELTA_CLAMP)
			return 9'(`BEEB_DELTA_CLAMP);
		if (d < -`BEEB_DELTA_CLAMP)
			return 9'(-`BEEB_DELTA_CLAMP);
		return d;
	endfunction

	// keep the position inside one signed byte
	function automatic logic signed [8:0] sat_pos(input logic signed [8:0] v);
		if (v < `BEEB_POS_MIN)
			return 9'(`BEEB_POS_MIN);
		if (v > `BEEB_POS_MAX)
			return 9'(`BEEB_POS_MAX);
		return v;
	endfunction

	// offset binary then inverted for the adc
	function automatic logic [7:0] format_axis(input logic [7:0] v);
		return 8'hff - {~v[7], v[6:0]};
	endfunction

	// ==================================================
	// position accumulator
	// ==================================================
	// sign bit widens each delta to nine bits
	assign dx_ext = {mouse.dx_sign, mouse.dx};
	assign dy_ext = {mouse.dy_sign, mouse.dy};
	// screen y grows downward, mouse dy grows upward
	assign sum_x = pos_x + clamp_delta(dx_ext);
	assign sum_y = pos_y - clamp_delta(dy_ext);

	assign pkt_new   = mouse.toggle != toggle_q;
	assign clear_req = (|joy.any_dir_or_button) || machine_reset || mouse_off;

	// free-running copy of the packet strobe
	always_ff @(posedge clk_sys) begin
		toggle_q <= mouse.toggle;
	end

	always_ff @(posedge clk_sys) begin
		if (rst || clear_req) begin
			// real joystick or reset takes over
			mouse_mode <= 1'b0;
			pos_x      <= '0;
			pos_y      <= '0;
		end else if (pkt_new) begin
			mouse_mode <= 1'b1;
			pos_x      <= sat_pos(sum_x);
			pos_y      <= sat_pos(sum_y);
		end
	end

	// output source
	always_comb begin
		axes.x    = format_axis(mouse_mode ? pos_x[7:0] : joy.x);
		axes.y    = format_axis(mouse_mode ? pos_y[7:0] : joy.y);
		axes.fire = mouse_mode ? |mouse.buttons : joy.fire;
	end

	// position never leaves the signed byte range
	assert property (@(posedge clk_sys) disable iff (rst)
		pos_x >= `BEEB_POS_MIN && pos_x <= `BEEB_POS_MAX &&
		pos_y >= `BEEB_POS_MIN && pos_y <= `BEEB_POS_MAX);

endmodule

// ==== design/sd_activity.sv ====
`include "beeb_settings.svh"

module sd_activity (
	input  logic clk_sys,
	input  logic rst,
	input  logic spi_mosi,
	input  logic spi_miso,
	output logic sd_act
);

	localparam int CNT_W = $clog2(`BEEB_SD_ACT_HOLD + 1);

	logic             mosi_q;
	logic             miso_q;
	logic             line_toggle;
	logic [CNT_W-1:0] hold_cnt;

	// line samples run through rst so no false edge follows it
	always_ff @(posedge clk_sys) begin
		mosi_q <= spi_mosi;
		miso_q <= spi_miso;
	end

	assign line_toggle = (mosi_q ^ spi_mosi) || (miso_q ^ spi_miso);

	// ==================================================
	// hold counter
	// ==================================================
	// restarts on any toggle, parks at the hold value
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			hold_cnt <= CNT_W'(`BEEB_SD_ACT_HOLD);
			sd_act   <= 1'b0;
		end else begin
			sd_act <= hold_cnt < CNT_W'(`BEEB_SD_ACT_HOLD);
			if (line_toggle)
				hold_cnt <= '0;
			else if (hold_cnt < CNT_W'(`BEEB_SD_ACT_HOLD))
				hold_cnt <= hold_cnt + 1'b1;
		end
	end

endmodule

// ==== design/beeb_glue_top.sv ====
module beeb_glue_top (
	input  logic                 clk_sys,
	input  logic                 rst,
	input  logic                 machine_reset,
	input  logic                 model_master,
	input  beeb_pkg::rom_load_t  rom_load,
	input  beeb_pkg::mem_bus_t   mem_req,
	input  beeb_pkg::mouse_pkt_t mouse,
	input  beeb_pkg::joy_in_t    joy,
	input  logic                 mouse_off,
	input  logic                 spi_mosi,
	input  logic                 spi_miso,
	output logic [7:0]           mem_rdata,
	output beeb_pkg::joy_axes_t  axes,
	output logic                 sd_act
);

	// ==================================================
	// core external memory
	// ==================================================
	mem_subsystem mem_subsystem_inst (
		.clk_sys       (clk_sys),
		.rst           (rst),
		.machine_reset (machine_reset),
		.model_master  (model_master),
		.rom_load      (rom_load),
		.mem_req       (mem_req),
		.mem_rdata     (mem_rdata)
	);

	// analog joystick, mouse or real stick
	mouse_joystick mouse_joystick_inst (
		.clk_sys       (clk_sys),
		.rst           (rst),
		.machine_reset (machine_reset),
		.mouse_off     (mouse_off),
		.mouse         (mouse),
		.joy           (joy),
		.axes          (axes)
	);

	// activity level from the physical card lines
	sd_activity sd_activity_inst (
		.clk_sys  (clk_sys),
		.rst      (rst),
		.spi_mosi (spi_mosi),
		.spi_miso (spi_miso),
		.sd_act   (sd_act)
	);

endmodule

// ==== bench/tb_clock.sv ====
module tb_clock (
	output logic clk_sys,
	output logic rst
);

	timeunit 1ns;
	timeprecision 1ps;

	// 8 ns period
	initial clk_sys = 1'b0;
	always #4 clk_sys = ~clk_sys;

	// rst held for 8 cycles, released on a falling edge
	initial begin
		rst = 1'b1;
		repeat (8) @(posedge clk_sys);
		@(negedge clk_sys);
		rst = 1'b0;
	end

endmodule

// ==== bench/tb_beeb_glue.sv ====
`include "beeb_settings.svh"

module tb_beeb_glue;

	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		logic [16:0] addr;
		logic [7:0]  data;
	} ram_row_t;

	// mouse stimulus, joystick stimulus and expected signed axis values
	typedef struct packed {
		int pkt, dx, dy, btn, count, any, jx, jy, jfire, off, ex, ey, efire;
	} mouse_row_t;

	localparam int N_RAM = 8;
	localparam int N_MOUSE = 12;
	localparam int SD_BURSTS = 4;
	localparam int SD_GAP = 100;
	localparam int HOLD = `BEEB_SD_ACT_HOLD;
	localparam logic [12:0] W_OFF = 13'h0a5;
	localparam logic [3:0] B_SLOTS [4] = '{4'b0100, 4'b1000, 4'b1110, 4'b1111};
	localparam logic [3:0] M_SLOTS [10] = '{4'b0010, 4'b0011, 4'b0100, 4'b1001, 4'b1010,
		4'b1011, 4'b1100, 4'b1101, 4'b1110, 4'b1111};

	// pkt dx dy btn count | any jx jy jfire off | ex ey efire
	localparam mouse_row_t MOUSE_TABLE [N_MOUSE] = '{
		'{1, 3, 2, 0, 1, 0, 0, 0, 0, 0, 3, -2, 0},
		'{1, 25, -40, 1, 1, 0, 0, 0, 0, 0, 13, 8, 1},
		'{1, -200, 255, 2, 1, 0, 0, 0, 0, 0, 3, -2, 1},
		'{1, -7, 0, 0, 1, 0, 0, 0, 0, 0, -4, -2, 0},
		'{1, 100, -100, 3, 14, 0, 0, 0, 0, 0, 127, 127, 1},
		'{1, -255, 255, 0, 30, 0, 0, 0, 0, 0, -128, -128, 0},
		'{1, 1, -1, 0, 1, 0, 0, 0, 0, 0, -127, -127, 0},
		'{0, 0, 0, 0, 1, 16, 60, -46, 1, 0, 60, -46, 1},
		'{1, 5, 5, 0, 1, 0, 60, -46, 1, 0, 5, -5, 0},
		'{0, 0, 0, 0, 1, 0, 60, -46, 1, 1, 60, -46, 1},
		'{1, 9, 9, 3, 2, 0, 60, -46, 1, 1, 60, -46, 1},
		'{0, 0, 0, 0, 1, 0, 60, -46, 1, 0, 60, -46, 1}
	};

	logic                 clk_sys;
	logic                 rst;
	logic                 machine_reset;
	logic                 model_master;
	logic                 mouse_off;
	logic                 spi_mosi;
	logic                 spi_miso;
	logic                 sd_act;
	logic [7:0]           mem_rdata;
	beeb_pkg::rom_load_t  rom_load;
	beeb_pkg::mem_bus_t   mem_req;
	beeb_pkg::mouse_pkt_t mouse;
	beeb_pkg::joy_in_t    joy;
	beeb_pkg::joy_axes_t  axes;
	logic [15:0]          lfsr_state = 16'd79;
	logic [15:0]          rom_words [`BEEB_ROM_BANKS];
	ram_row_t             ram_table [N_RAM];
	int                   cycles = 0;
	int                   cycle_limit;

	tb_clock tb_clock_inst (.clk_sys(clk_sys), .rst(rst));

	beeb_glue_top beeb_glue_top_inst (
		.clk_sys(clk_sys), .rst(rst), .machine_reset(machine_reset),
		.model_master(model_master), .rom_load(rom_load), .mem_req(mem_req),
		.mouse(mouse), .joy(joy), .mouse_off(mouse_off), .spi_mosi(spi_mosi),
		.spi_miso(spi_miso), .mem_rdata(mem_rdata), .axes(axes), .sd_act(sd_act)
	);

	// ==================================================
	// helpers
	// ==================================================
	// galois lfsr with taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	// one step per bit taken
	function logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// b slots fill physical 0..3 and master slots 4..13 while the rest read zero
	function automatic logic [7:0] rom_expect(input logic master, input logic [3:0] slot,
		input logic odd);
		int p;
		p = -1;
		for (int i = 0; i < 4; i++)
			if (!master && B_SLOTS[i] == slot) p = i;
		for (int i = 0; i < 10; i++)
			if (master && M_SLOTS[i] == slot) p = 4 + i;
		if (p < 0) return 8'h00;
		return odd ? rom_words[p][7:0] : rom_words[p][15:8];
	endfunction

	// offset binary then inverted equals 127 minus the signed value
	function automatic logic [7:0] axis_code(input int v);
		return 8'(127 - v);
	endfunction

	// twice the phase lengths plus the activity hold
	function automatic int cycle_budget();
		int sum;
		sum = 10 + `BEEB_ROM_BANKS + 3 * 32 + 4 + N_RAM * 6;
		sum += SD_BURSTS * SD_GAP + HOLD + 4;
		for (int i = 0; i < N_MOUSE; i++)
			sum += (MOUSE_TABLE[i].pkt != 0) ? MOUSE_TABLE[i].count : 1;
		return 2 * sum + HOLD;
	endfunction

	task automatic abort_run();
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] want);
		if (got !== want) begin
			$display("error %s: got %h, expected %h", name, got, want);
			abort_run();
		end
	endtask

	task automatic check_axes(input beeb_pkg::joy_axes_t got, input beeb_pkg::joy_axes_t want);
		if (got !== want) begin
			$display("error axes: got x=%h y=%h fire=%h, expected x=%h y=%h fire=%h",
				got.x, got.y, got.fire, want.x, want.y, want.fire);
			abort_run();
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic want);
		if (got !== want) begin
			$display("error %s: got %h, expected %h", name, got, want);
			abort_run();
		end
	endtask

	// all bus tasks start and end just after a falling edge
	task automatic bus_read(input logic [18:0] addr, output logic [7:0] data);
		mem_req.we_n = 1'b1;
		mem_req.addr = addr;
		@(negedge clk_sys);
		data = mem_rdata;
	endtask

	// one low pulse of we_n then back high
	task automatic bus_write(input logic [18:0] addr, input logic [7:0] data);
		mem_req = '{we_n: 1'b0, addr: addr, wdata: data};
		@(negedge clk_sys);
		mem_req.we_n = 1'b1;
		@(negedge clk_sys);
	endtask

	// every slot at the even and odd byte of the loaded word
	task automatic rom_sweep(input logic master);
		logic [18:0] addr;
		logic [7:0]  data;
		for (int s = 0; s < 16; s++) begin
			for (int odd = 0; odd < 2; odd++) begin
				addr = {1'b0, 4'(s), W_OFF, odd[0]};
				bus_read(addr, data);
				check_byte($sformatf("mem_rdata at %h", addr), data,
					rom_expect(master, 4'(s), odd[0]));
			end
		end
	endtask

	task automatic apply_mouse_row(input mouse_row_t r);
		beeb_pkg::joy_axes_t want;
		joy = '{any_dir_or_button: 16'(r.any), x: 8'(r.jx), y: 8'(r.jy), fire: r.jfire[0]};
		mouse_off = r.off[0];
		mouse.buttons = 2'(r.btn);
		{mouse.dx_sign, mouse.dx} = 9'(r.dx);
		{mouse.dy_sign, mouse.dy} = 9'(r.dy);
		if (r.pkt != 0) begin
			// a new packet on every flip of the toggle
			repeat (r.count) begin
				mouse.toggle = ~mouse.toggle;
				@(negedge clk_sys);
			end
		end else begin
			@(negedge clk_sys);
		end
		want = '{x: axis_code(r.ex), y: axis_code(r.ey), fire: r.efire[0]};
		check_axes(axes, want);
	endtask

	// ==================================================
	// timeout
	// ==================================================
	always @(posedge clk_sys) begin
		cycles = cycles + 1;
		if (cycles > cycle_limit) begin
			$display("timeout: run went past %0d cycles", cycle_limit);
			abort_run();
		end
	end

	// ==================================================
	// test sequence
	// ==================================================
	initial begin
		logic [7:0] data;
		machine_reset = 1'b1;
		model_master = 1'b0;
		rom_load = '0;
		mem_req = '0;
		mem_req.we_n = 1'b1;
		mouse = '0;
		joy = '0;
		mouse_off = 1'b0;
		spi_mosi = 1'b0;
		spi_miso = 1'b0;
		// low byte carries the bank number so every word differs
		for (int p = 0; p < `BEEB_ROM_BANKS; p++)
			rom_words[p] = {8'(take_bits(8)), 4'ha, 4'(p)};
		for (int i = 0; i < N_RAM; i++)
			ram_table[i] = '{addr: 17'(take_bits(17)), data: 8'(take_bits(8))};
		cycle_limit = cycle_budget();
		wait (!rst);
		@(negedge clk_sys);
		check_level("sd_act", sd_act, 1'b0);

		// loader runs while the machine is held with model b latched
		for (int p = 0; p < `BEEB_ROM_BANKS; p++) begin
			rom_load = '{wr: 1'b1, addr: {4'(p), W_OFF}, data: rom_words[p]};
			@(negedge clk_sys);
			rom_load.wr = 1'b0;
		end
		machine_reset = 1'b0;
		@(negedge clk_sys);
		rom_sweep(1'b0);
		// model change ignored until the next machine reset
		model_master = 1'b1;
		@(negedge clk_sys);
		rom_sweep(1'b0);
		machine_reset = 1'b1;
		@(negedge clk_sys);
		machine_reset = 1'b0;
		rom_sweep(1'b1);

		// ram write and readback then a write below bit 18 must not land
		for (int i = 0; i < N_RAM; i++) begin
			bus_write({2'b10, ram_table[i].addr}, ram_table[i].data);
			bus_read({2'b10, ram_table[i].addr}, data);
			check_byte("mem_rdata", data, ram_table[i].data);
			bus_write({2'b00, ram_table[i].addr}, ~ram_table[i].data);
			bus_read({2'b10, ram_table[i].addr}, data);
			check_byte("mem_rdata", data, ram_table[i].data);
		end

		for (int i = 0; i < N_MOUSE; i++)
			apply_mouse_row(MOUSE_TABLE[i]);

		// sd activity rises one cycle after the edge that sees a toggle
		spi_mosi = ~spi_mosi;
		repeat (2) @(negedge clk_sys);
		check_level("sd_act", sd_act, 1'b1);
		for (int i = 0; i < SD_BURSTS; i++) begin
			if (i[0])
				spi_miso = ~spi_miso;
			else
				spi_mosi = ~spi_mosi;
			repeat (SD_GAP) @(negedge clk_sys);
			check_level("sd_act", sd_act, 1'b1);
		end
		// last toggle then the exact fall
		spi_miso = ~spi_miso;
		repeat (HOLD + 1) @(negedge clk_sys);
		check_level("sd_act", sd_act, 1'b1);
		@(negedge clk_sys);
		check_level("sd_act", sd_act, 1'b0);

		$display("Verification passed");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+design
design/beeb_pkg.sv
design/rom_bank_map.sv
design/rom_store.sv
design/ram_store.sv
design/mem_subsystem.sv
design/mouse_joystick.sv
design/sd_activity.sv
design/beeb_glue_top.sv
bench/tb_clock.sv
bench/tb_beeb_glue.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert --top-module tb_beeb_glue -f src.f -o sim_beeb \
	&& ./obj_dir/sim_beeb \
	|| { echo "simulation did not complete successfully"; exit 1; }
